/* calc_uart_top.f */
+incdir+hw
hw/uart_pkg.sv
hw/calc_pkg.sv
hw/tx_req_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_parser.sv
hw/tx_arbiter.sv
hw/calc_uart_top.sv
tb/tb_calc_uart.sv

/* hw/calc_consts.svh */
// --------------------------------------------------
// bit timing, frame size and character codes
// shared by the serial calculator blocks
// --------------------------------------------------
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// bit timing, one CLKOP counter per serial bit
`define CALC_CLKS_PER_BIT 16      // CLKOP cycles per bit
`define CALC_DATA_BITS    8       // 8N1 data field
`define CALC_FRAME_BITS   10      // start + data + stop

// character codes
`define CALC_CHR_ESC      8'h1B   // abort, never echoed
`define CALC_CHR_PLUS     8'h2B   // '+'
`define CALC_CHR_MINUS    8'h2D   // '-'

// digits are 0x30..0x3F, operand is the low nibble
`define CALC_DIGIT_CLASS  4'h3

// result code 0..31 maps onto '@'..'_'
`define CALC_RESULT_BASE  8'h40

`endif

/* hw/calc_pkg.sv */
// --------------------------------------------------
// calculator types: byte view union, operator kind,
// result code
// --------------------------------------------------
`default_nettype none

package calc_pkg;
   import uart_pkg::*;

   // same received byte, two decodes
   typedef union packed {
      uart_byte_t raw;          // whole character, for '+' '-' ESC compares
      struct packed {
         logic [3:0] cls;       // upper nibble, 3 for a digit
         logic [3:0] val;       // operand value
      } nib;
   } calc_char_u;

   typedef enum logic {
      OP_ADD = 1'b0,
      OP_SUB = 1'b1
   } calc_op_e;

   typedef logic [4:0] calc_result_t;   // carry/sum, bit 4 is carry

endpackage

`default_nettype wire

/* hw/calc_uart_top.sv */
// --------------------------------------------------
// serial calculator top: receiver/echo, parser,
// arbiter and transmitter
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module calc_uart_top
   import uart_pkg::*;
(
   input  logic CLKOP,
   input  logic i_rst,
   input  logic i_rx_serial,
   output logic o_tx_serial
);

   uart_byte_t rx_byte;     // received char, valid with rx_valid
   logic       rx_valid;
   logic       tx_start;
   uart_byte_t tx_byte;
   logic       tx_done;

   tx_req_if echo_bus ();    // rx echo -> arbiter
   tx_req_if result_bus ();  // parser result -> arbiter

   uart_rx i_uart_rx (
      .CLKOP       (CLKOP),
      .i_rst       (i_rst),
      .i_rx_serial (i_rx_serial),
      .o_rx_byte   (rx_byte),
      .o_rx_valid  (rx_valid),
      .echo_bus    (echo_bus.requester)
   );

   cmd_parser i_cmd_parser (
      .CLKOP      (CLKOP),
      .i_rst      (i_rst),
      .i_rx_byte  (rx_byte),
      .i_rx_valid (rx_valid),
      .result_bus (result_bus.requester)
   );

   tx_arbiter i_tx_arbiter (
      .CLKOP      (CLKOP),
      .i_rst      (i_rst),
      .echo_bus   (echo_bus.arbiter),
      .result_bus (result_bus.arbiter),
      .o_tx_start (tx_start),
      .o_tx_byte  (tx_byte),
      .i_tx_done  (tx_done)
   );

   uart_tx i_uart_tx (
      .CLKOP       (CLKOP),
      .i_rst       (i_rst),
      .i_tx_start  (tx_start),
      .i_tx_byte   (tx_byte),
      .o_tx_done   (tx_done),
      .o_tx_serial (o_tx_serial)
   );

endmodule

`default_nettype wire

/* hw/cmd_parser.sv */
// --------------------------------------------------
// parser for commands of two digits and an operator
// 4-bit add/subtract and result character slot
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "calc_consts.svh"

module cmd_parser
   import uart_pkg::*, calc_pkg::*;
(
   input  logic        CLKOP,
   input  logic        i_rst,
   input  uart_byte_t  i_rx_byte,
   input  logic        i_rx_valid,
   tx_req_if.requester result_bus
);

   calc_char_u   chr;
   calc_op_e     op;
   calc_result_t code;
   logic [1:0]   pos;          // chars seen in this command
   logic [3:0]   op_a;
   logic [3:0]   op_b;
   logic [3:0]   b_term;
   logic         is_digit;
   logic         is_oper;
   logic         result_load;

   // ------------------------------------------------
   // character decode
   // ------------------------------------------------
   assign chr.raw  = i_rx_byte;
   assign is_digit = (chr.nib.cls == `CALC_DIGIT_CLASS);   // '0'..'?'
   assign is_oper  = (chr.raw == `CALC_CHR_PLUS) || (chr.raw == `CALC_CHR_MINUS);
   assign op       = (chr.raw == `CALC_CHR_MINUS) ? OP_SUB : OP_ADD;

   // a - b as a + ~b + 1 with carry out in bit 4 when a >= b
   assign b_term = (op == OP_SUB) ? ~op_b : op_b;
   assign code   = {1'b0, op_a} + {1'b0, b_term} + {4'b0000, (op == OP_SUB)};

   // third char completes the command into the single result slot
   assign result_load = i_rx_valid && (pos == 2'd2) && is_oper && !result_bus.req;

   // ------------------------------------------------
   // position count
   // ------------------------------------------------
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         pos <= 2'd0;
      end else if (i_rx_valid) begin
         if (pos == 2'd2) begin
            pos <= 2'd0;            // operator or junk ends the command
         end else if (is_digit) begin
            pos <= pos + 2'd1;
         end else begin
            pos <= 2'd0;            // ESC or any non-digit restarts
         end
      end
   end

   // operand capture
   always_ff @(posedge CLKOP) begin
      if (i_rx_valid && is_digit) begin
         if (pos == 2'd0) op_a <= chr.nib.val;
         if (pos == 2'd1) op_b <= chr.nib.val;
      end
   end

   // ------------------------------------------------
   // result slot
   // ------------------------------------------------
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         result_bus.req <= 1'b0;
      end else if (result_load) begin
         result_bus.req <= 1'b1;        // held until the arbiter grants
      end else if (result_bus.grant && result_bus.busy) begin
         result_bus.req <= 1'b0;
      end
   end

   // code 0..31 lands on '@'..'_'
   always_ff @(posedge CLKOP) begin
      if (result_load) result_bus.data <= `CALC_RESULT_BASE + {3'b000, code};
   end

endmodule

`default_nettype wire

/* hw/tx_arbiter.sv */
// --------------------------------------------------
// fixed-priority arbiter, echo over result, in front
// of the single transmitter
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter
   import uart_pkg::*;
(
   input  logic       CLKOP,
   input  logic       i_rst,
   tx_req_if.arbiter  echo_bus,
   tx_req_if.arbiter  result_bus,
   output logic       o_tx_start,
   output uart_byte_t o_tx_byte,
   input  logic       i_tx_done
);

   tx_src_e owner;           // source of the frame on the line
   logic    busy;
   logic    echo_grant;
   logic    result_grant;

   // ------------------------------------------------
   // grant and line ownership
   // ------------------------------------------------
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         owner        <= SRC_ECHO;
         busy         <= 1'b0;
         echo_grant   <= 1'b0;
         result_grant <= 1'b0;
         o_tx_start   <= 1'b0;
      end else begin
         echo_grant   <= 1'b0;      // pulses
         result_grant <= 1'b0;
         o_tx_start   <= 1'b0;
         if (!busy) begin
            if (echo_bus.req) begin            // echo wins ties
               owner      <= SRC_ECHO;
               busy       <= 1'b1;
               echo_grant <= 1'b1;
               o_tx_start <= 1'b1;
            end else if (result_bus.req) begin
               owner        <= SRC_RESULT;
               busy         <= 1'b1;
               result_grant <= 1'b1;
               o_tx_start   <= 1'b1;
            end
         end else if (i_tx_done) begin
            busy <= 1'b0;                      // stop bit finished
         end
      end
   end

   // requester data still held during the start cycle
   assign o_tx_byte = (owner == SRC_RESULT) ? result_bus.data : echo_bus.data;

   assign echo_bus.grant   = echo_grant;
   assign result_bus.grant = result_grant;
   assign echo_bus.busy    = busy;
   assign result_bus.busy  = busy;

endmodule

`default_nettype wire

/* hw/tx_req_if.sv */
// --------------------------------------------------
// transmit request bus between one requester and
// the transmit arbiter
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface tx_req_if
   import uart_pkg::*;
();

   logic       req;     // level, up with data valid, held until grant
   uart_byte_t data;    // stable while req high
   logic       grant;   // one cycle, arbiter took the byte
   logic       busy;    // line is sending something

   // requester side, drops req the cycle after grant
   modport requester (
      output req,
      output data,
      input  grant,
      input  busy
   );

   // arbiter side
   modport arbiter (
      input  req,
      input  data,
      output grant,
      output busy
   );

endinterface

`default_nettype wire

/* hw/uart_pkg.sv */
// --------------------------------------------------
// serial byte type and transmit owner encoding
// --------------------------------------------------
`default_nettype none

package uart_pkg;

   // one data byte on the line, lsb goes out first
   typedef logic [7:0] uart_byte_t;

   // who currently owns the transmitter
   typedef enum logic {
      SRC_ECHO   = 1'b0,   // received char going back out
      SRC_RESULT = 1'b1    // computed result char
   } tx_src_e;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
// --------------------------------------------------
// 8N1 serial receiver with mid-bit sampling
// also owns the one-byte echo slot
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "calc_consts.svh"

module uart_rx
   import uart_pkg::*;
(
   input  logic        CLKOP,
   input  logic        i_rst,
   input  logic        i_rx_serial,
   output uart_byte_t  o_rx_byte,
   output logic        o_rx_valid,
   tx_req_if.requester echo_bus
);

   localparam int CLKS  = `CALC_CLKS_PER_BIT;
   localparam int CNT_W = $clog2(CLKS);
   localparam int BIT_W = $clog2(`CALC_DATA_BITS);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e        state;
   logic [CNT_W-1:0] clk_cnt;     // cycles inside the current bit
   logic [BIT_W-1:0] bit_idx;     // data bit number
   uart_byte_t       shift_q;
   logic             bit_end;
   logic             half_bit;
   logic             stop_ok;
   logic             echo_load;

   assign bit_end   = (clk_cnt == CNT_W'(CLKS - 1));
   assign half_bit  = (clk_cnt == CNT_W'(CLKS / 2 - 1));
   assign stop_ok   = (state == RX_STOP) && bit_end && i_rx_serial;  // good stop bit
   // ESC is swallowed, full slot drops the new echo
   assign echo_load = stop_ok && (shift_q != `CALC_CHR_ESC) && !echo_bus.req;

   // ------------------------------------------------
   // frame FSM
   // ------------------------------------------------
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         state      <= RX_IDLE;
         clk_cnt    <= '0;
         bit_idx    <= '0;
         o_rx_valid <= 1'b0;
      end else begin
         o_rx_valid <= stop_ok;
         clk_cnt    <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!i_rx_serial) state <= RX_START;   // falling edge
            end
            RX_START: begin
               if (half_bit) begin                    // middle of start bit
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  state   <= i_rx_serial ? RX_IDLE : RX_DATA;  // glitch, back off
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == BIT_W'(`CALC_DATA_BITS - 1)) state <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (bit_end) state <= RX_IDLE;         // mid stop bit
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // data path, lsb arrives first
   always_ff @(posedge CLKOP) begin
      if (state == RX_DATA && bit_end) shift_q <= {i_rx_serial, shift_q[7:1]};
      if (stop_ok) o_rx_byte <= shift_q;
   end

   // ------------------------------------------------
   // echo slot
   // ------------------------------------------------
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         echo_bus.req <= 1'b0;
      end else if (echo_load) begin
         echo_bus.req <= 1'b1;
      end else if (echo_bus.grant && echo_bus.busy) begin
         echo_bus.req <= 1'b0;   // arbiter has the line and the byte
      end
   end

   always_ff @(posedge CLKOP) begin
      if (echo_load) echo_bus.data <= shift_q;
   end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
// --------------------------------------------------
// 8N1 serial transmitter, one frame per start strobe
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "calc_consts.svh"

module uart_tx
   import uart_pkg::*;
(
   input  logic       CLKOP,
   input  logic       i_rst,
   input  logic       i_tx_start,
   input  uart_byte_t i_tx_byte,
   output logic       o_tx_done,
   output logic       o_tx_serial
);

   localparam int CLKS   = `CALC_CLKS_PER_BIT;
   localparam int CNT_W  = $clog2(CLKS);
   localparam int FRAME  = `CALC_FRAME_BITS;
   localparam int FBIT_W = $clog2(FRAME);

   logic                     active;
   logic [CNT_W-1:0]         clk_cnt;
   logic [FBIT_W-1:0]        bit_cnt;    // 0 start, 1..8 data, 9 stop
   logic [`CALC_DATA_BITS:0] shift_q;    // data plus stop bit
   logic                     bit_end;
   logic                     last_bit;

   assign bit_end  = (clk_cnt == CNT_W'(CLKS - 1));
   assign last_bit = (bit_cnt == FBIT_W'(FRAME - 1));

   // bit timing and line driver
   always_ff @(posedge CLKOP) begin
      if (i_rst) begin
         active      <= 1'b0;
         clk_cnt     <= '0;
         bit_cnt     <= '0;
         o_tx_done   <= 1'b0;
         o_tx_serial <= 1'b1;      // idle line is mark
      end else begin
         o_tx_done <= 1'b0;
         if (!active) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            if (i_tx_start) begin
               active      <= 1'b1;
               o_tx_serial <= 1'b0;   // start bit from next cycle
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (bit_end) begin
               clk_cnt <= '0;
               bit_cnt <= bit_cnt + 1'b1;
               if (last_bit) begin
                  active    <= 1'b0;  // stop bit done
                  o_tx_done <= 1'b1;
               end else begin
                  o_tx_serial <= shift_q[0];
               end
            end
         end
      end
   end

   // shifter, refills with mark
   always_ff @(posedge CLKOP) begin
      if (!active && i_tx_start) begin
         shift_q <= {1'b1, i_tx_byte};
      end else if (active && bit_end) begin
         shift_q <= {1'b1, shift_q[`CALC_DATA_BITS:1]};
      end
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the calculator testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_calc_uart -f calc_uart_top.f \
   -o tb_calc_uart \
   && ./obj_dir/tb_calc_uart > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "Verification passed" sim.log \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation did not pass"; exit 1; }

/* tb/tb_calc_uart.sv */
// --------------------------------------------------
// testbench for the serial calculator: serial driver,
// line monitor, reference model, compare process
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "calc_consts.svh"

module tb_calc_uart
   import uart_pkg::*, calc_pkg::*;
();

   localparam int CLKS       = `CALC_CLKS_PER_BIT;
   localparam int FRAME_CLKS = `CALC_FRAME_BITS * CLKS;
   localparam int DRAIN_MAX  = 8 * FRAME_CLKS;     // cycles allowed for replies

   logic CLKOP;
   logic i_rst;
   logic i_rx_serial;
   logic o_tx_serial;

   uart_byte_t exp_q[$];      // expected chars in line order
   tx_src_e    src_q[$];      // echo or result, per expected char
   uart_byte_t rcv_q[$];      // decoded from o_tx_serial

   int unsigned err_cnt;
   int unsigned chk_cnt;
   int unsigned test_err0;    // error count when the test began
   int unsigned seed_val;
   int          ref_pos;      // model parse position 0..2
   int          ref_a;
   int          ref_b;

   calc_uart_top i_calc_uart_top (
      .CLKOP       (CLKOP),
      .i_rst       (i_rst),
      .i_rx_serial (i_rx_serial),
      .o_tx_serial (o_tx_serial)
   );

   initial begin
      CLKOP = 1'b0;
      forever #50 CLKOP = ~CLKOP;   // 100 ns period
   end

   // --------------------------------------------------
   // reference model, one call per sent char
   // --------------------------------------------------
   function automatic void calc_expect(input uart_byte_t chr);
      int code;
      if (chr != `CALC_CHR_ESC) begin
         exp_q.push_back(chr);       // everything but ESC comes back
         src_q.push_back(SRC_ECHO);
      end
      if (chr == `CALC_CHR_ESC) begin
         ref_pos = 0;
      end else if (ref_pos == 2) begin
         ref_pos = 0;                // third char always ends the command
         if (chr == `CALC_CHR_PLUS || chr == `CALC_CHR_MINUS) begin
            if (chr == `CALC_CHR_PLUS)
               code = ref_a + ref_b;
            else
               code = ref_a - ref_b + 16;   // carry set when a >= b
            exp_q.push_back(uart_byte_t'(`CALC_RESULT_BASE | code));
            src_q.push_back(SRC_RESULT);
         end
      end else if (chr >= 8'h30 && chr <= 8'h3F) begin
         if (ref_pos == 0)
            ref_a = int'(chr[3:0]);
         else
            ref_b = int'(chr[3:0]);
         ref_pos = ref_pos + 1;
      end else begin
         ref_pos = 0;                // bad operand
      end
   endfunction

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic check_echo(input uart_byte_t got, input uart_byte_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED at %0t ns: echo 0x%02h, expected 0x%02h", $time, got, exp);
      end
   endtask

   task automatic check_result(input calc_result_t got, input calc_result_t exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED at %0t ns: result code %0d, expected %0d", $time, got, exp);
      end
   endtask

   // line decoder, samples each bit in its middle
   initial begin : line_monitor
      uart_byte_t chr;
      forever begin
         @(posedge CLKOP);
         if (i_rst === 1'b0 && o_tx_serial === 1'b0) begin
            repeat (CLKS / 2) @(posedge CLKOP);    // middle of start bit
            for (int i = 0; i < `CALC_DATA_BITS; i++) begin
               repeat (CLKS) @(posedge CLKOP);
               chr[i] = o_tx_serial;               // lsb first
            end
            repeat (CLKS) @(posedge CLKOP);
            if (o_tx_serial !== 1'b1) begin
               err_cnt++;
               $display("stop bit missing on the DUT output at %0t ns", $time);
            end
            rcv_q.push_back(chr);
         end
      end
   end

   // pops on the falling edge, away from the monitor pushes
   initial begin : compare_proc
      uart_byte_t got;
      uart_byte_t exp;
      tx_src_e    src;
      forever begin
         @(negedge CLKOP);
         if (rcv_q.size() > 0) begin
            got = rcv_q.pop_front();
            if (exp_q.size() == 0) begin
               err_cnt++;
               $display("DUT sent char 0x%02h when none was due, at %0t ns", got, $time);
            end else begin
               exp = exp_q.pop_front();
               src = src_q.pop_front();
               if (src == SRC_ECHO) begin
                  check_echo(got, exp);
               end else begin
                  if (got[7:5] !== 3'b010) begin   // result chars are '@'..'_'
                     err_cnt++;
                     $display("FAILED at %0t ns: result char 0x%02h off base", $time, got);
                  end
                  check_result(calc_result_t'(got[4:0]), calc_result_t'(exp[4:0]));
               end
            end
         end
      end
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic send_byte(input uart_byte_t chr);
      logic [9:0] frame;
      frame = {1'b1, chr, 1'b0};     // stop, data, start
      calc_expect(chr);
      for (int i = 0; i < `CALC_FRAME_BITS; i++) begin
         i_rx_serial <= frame[i];
         repeat (CLKS) @(posedge CLKOP);
      end
      repeat (2 * FRAME_CLKS) @(posedge CLKOP);   // two idle frames
   endtask

   function automatic uart_byte_t rand_digit();
      logic [3:0] v;
      v = 4'($urandom_range(15, 0));
      return {4'h3, v};
   endfunction

   task automatic send_cmd(input uart_byte_t a, input uart_byte_t b, input uart_byte_t op);
      send_byte(a);
      send_byte(b);
      send_byte(op);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() > 0 && waited < DRAIN_MAX) begin
         @(posedge CLKOP);
         waited++;
      end
      if (exp_q.size() > 0) begin
         $display("timeout, %0d expected chars never came from the DUT", exp_q.size());
         $display("Verification failed");
         $finish;
      end
   endtask

   task automatic end_test(input string name);
      wait_drain();
      repeat (2 * FRAME_CLKS) @(posedge CLKOP);   // room for stray chars
      $display("test %s done, %0d errors", name, err_cnt - test_err0);
      test_err0 = err_cnt;
   endtask

   initial begin
      int idle_bad;
      seed_val  = $urandom(32'h43e5);
      err_cnt   = 0;
      chk_cnt   = 0;
      test_err0 = 0;
      ref_pos   = 0;
      ref_a     = 0;
      ref_b     = 0;
      idle_bad  = 0;
      i_rst       <= 1'b1;
      i_rx_serial <= 1'b1;            // line idles at mark
      repeat (10) @(posedge CLKOP);
      i_rst <= 1'b0;

      // 1: quiet line after reset
      for (int i = 0; i < 4 * FRAME_CLKS; i++) begin
         @(posedge CLKOP);
         if (o_tx_serial !== 1'b1) idle_bad++;
      end
      chk_cnt++;
      if (idle_bad != 0) begin
         err_cnt++;
         $display("FAILED at %0t ns: o_tx_serial left idle %0d times", $time, idle_bad);
      end
      end_test("reset_idle");

      // 2: non-digits, echo only
      send_byte(8'h41);
      send_byte(8'h20);
      send_byte(8'h7A);
      send_byte(8'h2F);
      send_byte(`CALC_CHR_PLUS);     // operator in first position
      send_byte(8'h40);
      end_test("non_digit");

      // 3 and 4: random operands
      for (int i = 0; i < 8; i++) send_cmd(rand_digit(), rand_digit(), `CALC_CHR_PLUS);
      end_test("add");
      send_cmd(8'h37, 8'h37, `CALC_CHR_MINUS);   // a == b, carry set
      send_cmd(8'h30, 8'h3F, `CALC_CHR_MINUS);   // largest borrow
      for (int i = 0; i < 8; i++) send_cmd(rand_digit(), rand_digit(), `CALC_CHR_MINUS);
      end_test("sub");

      // 5: bad third char, then a clean command
      send_cmd(8'h33, 8'h35, 8'h3D);
      send_cmd(8'h32, 8'h34, `CALC_CHR_PLUS);
      send_cmd(8'h31, 8'h32, 8'h39);              // digit in operator slot
      send_cmd(8'h34, 8'h31, `CALC_CHR_MINUS);
      end_test("bad_operator");

      // 6: ESC drops partial operands
      send_byte(8'h35);
      send_byte(`CALC_CHR_ESC);
      send_cmd(8'h32, 8'h33, `CALC_CHR_PLUS);
      send_byte(8'h38);
      send_byte(8'h39);
      send_byte(`CALC_CHR_ESC);
      send_cmd(8'h31, 8'h31, `CALC_CHR_MINUS);
      end_test("escape");

      $display("%0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
